/* common/mem_geom_pkg.sv */
// memory geometry: word and block sizes, region addressing and cache ids
`default_nettype none

package mem_geom_pkg;

  // word and block sizes
  localparam int data_width_c = 32;
  localparam int block_words_c = 4;
  localparam int block_width_c = data_width_c * block_words_c;

  // word address inside one cache's region
  localparam int addr_width_c = 12;

  // widest id field supported
  localparam int max_caches_c = 4;

  typedef logic [data_width_c-1:0] word_t;
  typedef logic [block_width_c-1:0] block_t;
  typedef logic [addr_width_c-1:0] word_addr_t;

  // block address drops the word offset
  typedef logic [addr_width_c-$clog2(block_words_c)-1:0] block_addr_t;

  typedef logic [$clog2(max_caches_c)-1:0] cache_id_t;

endpackage

`default_nettype wire

/* common/mem_pkt_pkg.sv */
// packet formats for the link side, the cache DMA side and the memory side
`default_nettype none

package mem_pkt_pkg;

  // network request into a cache
  typedef struct packed {
    logic                     write;
    mem_geom_pkg::word_addr_t addr;
    mem_geom_pkg::word_t      data;
  } link_req_s;

  // cache response back to the network
  typedef struct packed {
    logic                write;
    mem_geom_pkg::word_t data;
  } link_rsp_s;

  // whole-block transfer issued by one cache
  typedef struct packed {
    logic                      write;
    mem_geom_pkg::block_addr_t addr;
    mem_geom_pkg::block_t      data;
  } dma_pkt_s;

  // dma packet after arbitration, tagged with its source
  typedef struct packed {
    mem_geom_pkg::cache_id_t id;
    dma_pkt_s                pkt;
  } mem_req_s;

  // read return from memory
  typedef struct packed {
    mem_geom_pkg::cache_id_t id;
    mem_geom_pkg::block_t    data;
  } mem_rsp_s;

endpackage

`default_nettype wire

/* compile.f */
common/mem_geom_pkg.sv
common/mem_pkt_pkg.sv
vcache/vcache_blocking.sv
dram/dma_arbiter.sv
dram/block_mem.sv
src/mem_system_top.sv
test/tb_mem_system.sv

/* dram/block_mem.sv */
// backing memory: one block region per cache, reads return after a fixed latency
`default_nettype none

module block_mem #(
  parameter int num_caches_p = 2,
  parameter int mem_latency_p = 4
) (
  input  logic                  core_clk,
  input  logic                  reset_i,

  input  logic                  req_v_i,
  input  mem_pkt_pkg::mem_req_s req_i,

  output logic                  rsp_v_o,
  output mem_pkt_pkg::mem_rsp_s rsp_o
);

  import mem_geom_pkg::*;
  import mem_pkt_pkg::*;

  localparam int region_blocks_lp = 2 ** $bits(block_addr_t);

  if (mem_latency_p < 1) begin : g_bad_latency
    $error("mem_latency_p must be at least 1");
  end

  block_t                   mem_r [num_caches_p * region_blocks_lp];
  logic [mem_latency_p-1:0] pipe_v_r;
  mem_rsp_s                 pipe_r [mem_latency_p];
  int                       row;

  assign row = int'(req_i.id) * region_blocks_lp + int'(req_i.pkt.addr);

  // preload puts the cache id above the word address
  initial begin
    for (int c = 0; c < num_caches_p; c++) begin
      for (int b = 0; b < region_blocks_lp; b++) begin
        for (int w = 0; w < block_words_c; w++) begin
          mem_r[c*region_blocks_lp + b][w*data_width_c +: data_width_c] =
            word_t'({cache_id_t'(c), word_addr_t'(b * block_words_c + w)});
        end
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (req_v_i && req_i.pkt.write) begin
      mem_r[row] <= req_i.pkt.data;
    end
  end

  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      pipe_v_r <= '0;
    end else begin
      pipe_v_r[0] <= req_v_i && !req_i.pkt.write;
      for (int i = 1; i < mem_latency_p; i++) begin
        pipe_v_r[i] <= pipe_v_r[i-1];
      end
    end
  end

  always_ff @(posedge core_clk) begin
    pipe_r[0].id <= req_i.id;
    pipe_r[0].data <= mem_r[row];
    for (int i = 1; i < mem_latency_p; i++) begin
      pipe_r[i] <= pipe_r[i-1];
    end
  end

  assign rsp_v_o = pipe_v_r[mem_latency_p-1];
  assign rsp_o = pipe_r[mem_latency_p-1];

  // arbiter tags only ids of existing caches
  assert property (@(posedge core_clk) disable iff (reset_i)
    req_v_i |-> int'(req_i.id) < num_caches_p);

endmodule

`default_nettype wire

/* dram/dma_arbiter.sv */
// dma arbiter: round-robin merge of cache block packets and return steering
`default_nettype none

module dma_arbiter #(
  parameter int num_caches_p = 2
) (
  input  logic                                     core_clk,
  input  logic                                     reset_i,

  input  logic [num_caches_p-1:0]                  dma_v_i,
  input  mem_pkt_pkg::dma_pkt_s [num_caches_p-1:0] dma_pkt_i,
  output logic [num_caches_p-1:0]                  dma_grant_o,

  output logic                                     mem_v_o,
  output mem_pkt_pkg::mem_req_s                    mem_req_o,

  input  logic                                     mem_rsp_v_i,
  input  mem_pkt_pkg::mem_rsp_s                    mem_rsp_i,

  output logic [num_caches_p-1:0]                  fill_v_o,
  output mem_geom_pkg::block_t [num_caches_p-1:0]  fill_o
);

  import mem_geom_pkg::*;

  cache_id_t ptr_r;
  cache_id_t win_id;
  logic      win_v;

  // first valid cache at or after the pointer
  always_comb begin
    int cand;
    win_v = 1'b0;
    win_id = '0;
    for (int k = 0; k < num_caches_p; k++) begin
      cand = (int'(ptr_r) + k) % num_caches_p;
      if (!win_v && dma_v_i[cand]) begin
        win_v = 1'b1;
        win_id = cache_id_t'(cand);
      end
    end
  end

  for (genvar i = 0; i < num_caches_p; i++) begin : g_port
    assign dma_grant_o[i] = win_v && (win_id == cache_id_t'(i));

    // memory only returns reads, so the id alone picks the owner
    assign fill_v_o[i] = mem_rsp_v_i && (mem_rsp_i.id == cache_id_t'(i));
    assign fill_o[i] = mem_rsp_i.data;
  end

  assign mem_v_o = win_v;
  assign mem_req_o.id = win_id;
  assign mem_req_o.pkt = dma_pkt_i[win_id];

  // pointer moves just past the winner
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      ptr_r <= '0;
    end else if (win_v) begin
      if (int'(win_id) == num_caches_p - 1) begin
        ptr_r <= '0;
      end else begin
        ptr_r <= win_id + 1'b1;
      end
    end
  end

  assert property (@(posedge core_clk) disable iff (reset_i)
    $onehot0(dma_grant_o) && ((dma_grant_o & ~dma_v_i) == '0));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_mem_system \
  -f compile.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete, see build.log" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

/* src/mem_system_top.sv */
// memory system: one vcache per column feeding a shared arbiter and block memory
`default_nettype none

module mem_system_top #(
  parameter int num_caches_p = 2,
  parameter int sets_p = 16,
  parameter int mem_latency_p = 4
) (
  input  logic                                      core_clk,
  input  logic                                      reset_i,

  input  logic [num_caches_p-1:0]                   req_v_i,
  input  mem_pkt_pkg::link_req_s [num_caches_p-1:0] req_i,
  output logic [num_caches_p-1:0]                   req_ready_o,

  output logic [num_caches_p-1:0]                   rsp_v_o,
  output mem_pkt_pkg::link_rsp_s [num_caches_p-1:0] rsp_o
);

  import mem_geom_pkg::*;
  import mem_pkt_pkg::*;

  logic [num_caches_p-1:0]     dma_v_lo;
  dma_pkt_s [num_caches_p-1:0] dma_pkt_lo;
  logic [num_caches_p-1:0]     dma_grant_li;
  logic [num_caches_p-1:0]     fill_v_li;
  block_t [num_caches_p-1:0]   fill_li;

  logic     mem_v_lo;
  mem_req_s mem_req_lo;
  logic     mem_rsp_v_li;
  mem_rsp_s mem_rsp_li;

  // level 1
  for (genvar i = 0; i < num_caches_p; i++) begin : g_col
    vcache_blocking #(
      .sets_p(sets_p)
      ,.num_caches_p(num_caches_p)
    ) vcache (
      .core_clk(core_clk)
      ,.reset_i(reset_i)
      ,.req_v_i(req_v_i[i])
      ,.req_i(req_i[i])
      ,.req_ready_o(req_ready_o[i])
      ,.rsp_v_o(rsp_v_o[i])
      ,.rsp_o(rsp_o[i])
      ,.dma_v_o(dma_v_lo[i])
      ,.dma_pkt_o(dma_pkt_lo[i])
      ,.dma_grant_i(dma_grant_li[i])
      ,.fill_v_i(fill_v_li[i])
      ,.fill_i(fill_li[i])
    );
  end

  // level 2
  dma_arbiter #(
    .num_caches_p(num_caches_p)
  ) arb (
    .core_clk(core_clk)
    ,.reset_i(reset_i)
    ,.dma_v_i(dma_v_lo)
    ,.dma_pkt_i(dma_pkt_lo)
    ,.dma_grant_o(dma_grant_li)
    ,.mem_v_o(mem_v_lo)
    ,.mem_req_o(mem_req_lo)
    ,.mem_rsp_v_i(mem_rsp_v_li)
    ,.mem_rsp_i(mem_rsp_li)
    ,.fill_v_o(fill_v_li)
    ,.fill_o(fill_li)
  );

  // level 3
  block_mem #(
    .num_caches_p(num_caches_p)
    ,.mem_latency_p(mem_latency_p)
  ) mem0 (
    .core_clk(core_clk)
    ,.reset_i(reset_i)
    ,.req_v_i(mem_v_lo)
    ,.req_i(mem_req_lo)
    ,.rsp_v_o(mem_rsp_v_li)
    ,.rsp_o(mem_rsp_li)
  );

endmodule

`default_nettype wire

/* test/tb_mem_system.sv */
// memory system testbench: directed and random traffic on both columns against a shadow model
`default_nettype none

module tb_mem_system;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_geom_pkg::*;
  import mem_pkt_pkg::*;

  localparam int num_ports_c = 2;
  localparam int sets_c = 16;
  localparam int mem_latency_c = 4;
  localparam int region_words_c = 2 ** addr_width_c;
  localparam int directed_per_port_c = 9;
  localparam int directed_writes_c = 3;
  localparam int random_per_port_c = 200;
  localparam int num_reqs_c = num_ports_c * (directed_per_port_c + random_per_port_c);
  localparam int watchdog_ns_c = (num_reqs_c * (2 * mem_latency_c + 10) + 20) * 8;
  localparam logic [31:0] lfsr_mask_c = 32'h8020_0003;

  logic                              core_clk;
  logic                              reset_i;
  logic [num_ports_c-1:0]            req_v;
  link_req_s [num_ports_c-1:0]       req;
  logic [num_ports_c-1:0]            req_ready;
  logic [num_ports_c-1:0]            rsp_v;
  link_rsp_s [num_ports_c-1:0]       rsp;

  // reference model
  word_t           shadow [num_ports_c][region_words_c];
  link_rsp_s       exp_q [num_ports_c][$];
  link_rsp_s [num_ports_c-1:0] exp_head;

  logic [31:0] lfsr_r;
  word_t       dir_data [num_ports_c][directed_writes_c];
  logic        rnd_wr [num_ports_c][random_per_port_c];
  logic        rnd_gap [num_ports_c][random_per_port_c];
  word_addr_t  rnd_addr [num_ports_c][random_per_port_c];
  word_t       rnd_data [num_ports_c][random_per_port_c];

  int value_errs;
  int other_errs;
  int acc_cnt [num_ports_c];
  int rsp_cnt [num_ports_c];

  mem_system_top #(
    .num_caches_p(num_ports_c)
    ,.sets_p(sets_c)
    ,.mem_latency_p(mem_latency_c)
  ) dut0 (
    .core_clk(core_clk)
    ,.reset_i(reset_i)
    ,.req_v_i(req_v)
    ,.req_i(req)
    ,.req_ready_o(req_ready)
    ,.rsp_v_o(rsp_v)
    ,.rsp_o(rsp)
  );

  always #4 core_clk = ~core_clk;

  // galois lfsr stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_r[0]};
      lfsr_r = lfsr_r[0] ? ((lfsr_r >> 1) ^ lfsr_mask_c) : (lfsr_r >> 1);
    end
    return v;
  endfunction

  // starts at a falling edge and returns at the falling edge after acceptance
  task automatic send_req(input int p, input logic wr, input word_addr_t a, input word_t d);
    link_req_s r;
    link_rsp_s e;
    r.write = wr;
    r.addr = a;
    r.data = d;
    req_v[p] = 1'b1;
    req[p] = r;
    while (!req_ready[p]) begin
      @(negedge core_clk);
    end
    e.write = wr;
    e.data = wr ? '0 : shadow[p][a];
    if (wr) begin
      shadow[p][a] = d;
    end
    exp_q[p].push_back(e);
    acc_cnt[p]++;
    @(negedge core_clk);
  endtask

  task automatic run_port(input int p);
    word_addr_t a;
    word_addr_t b;
    // untouched words show the preload
    send_req(p, 1'b0, 12'h3a5, '0);
    send_req(p, 1'b0, 12'h7f2, '0);
    // write miss followed by hits
    a = 12'h104;
    send_req(p, 1'b1, a, dir_data[p][0]);
    send_req(p, 1'b0, a, '0);
    send_req(p, 1'b1, a + 1, dir_data[p][1]);
    send_req(p, 1'b0, a + 1, '0);
    // another tag in the same set forces write-back and refill
    b = 12'h0c8;
    send_req(p, 1'b1, b, dir_data[p][2]);
    send_req(p, 1'b0, b + word_addr_t'(sets_c * block_words_c), '0);
    send_req(p, 1'b0, b, '0);
    for (int i = 0; i < random_per_port_c; i++) begin
      if (rnd_gap[p][i]) begin
        req_v[p] = 1'b0;
        @(negedge core_clk);
      end
      send_req(p, rnd_wr[p][i], rnd_addr[p][i], rnd_data[p][i]);
    end
    req_v[p] = 1'b0;
  endtask

  task automatic print_counts();
    $display("checks: %0d value errors, %0d other errors, accepted %0d/%0d, responses %0d/%0d",
             value_errs, other_errs, acc_cnt[0], acc_cnt[1], rsp_cnt[0], rsp_cnt[1]);
  endtask

  // pop the expected response that the next rising edge checks
  always @(negedge core_clk) begin
    if (!reset_i) begin
      for (int p = 0; p < num_ports_c; p++) begin
        if (rsp_v[p]) begin
          rsp_cnt[p]++;
          assert (exp_q[p].size() != 0) else begin
            other_errs++;
            $display("port %0d gave a response with no request outstanding", p);
          end
          if (exp_q[p].size() != 0) begin
            exp_head[p] = exp_q[p].pop_front();
          end
        end
      end
    end
  end

  assert property (@(posedge core_clk) $fell(reset_i) |-> (&req_ready) && (rsp_v == '0))
    else begin
      other_errs++;
      $display("ports were not idle when reset was released");
    end

  for (genvar p = 0; p < num_ports_c; p++) begin : g_chk
    assert property (@(posedge core_clk) disable iff (reset_i)
      rsp_v[p] |-> rsp[p] == exp_head[p])
      else begin
        value_errs++;
        $display("Error: rsp_o[%0d] = %h, expected %h", p, $sampled(rsp[p]),
                 $sampled(exp_head[p]));
      end

    // a busy port stays closed until its response strobe
    assert property (@(posedge core_clk) disable iff (reset_i)
      !req_ready[p] && !rsp_v[p] |=> !req_ready[p])
      else begin
        other_errs++;
        $display("port %0d took new requests again before answering the pending one", p);
      end
  end

  initial begin
    core_clk = 1'b0;
    reset_i = 1'b1;
    req_v = '0;
    req = '0;
    exp_head = '0;
    value_errs = 0;
    other_errs = 0;
    lfsr_r = 32'hd3e8;
    for (int p = 0; p < num_ports_c; p++) begin
      acc_cnt[p] = 0;
      rsp_cnt[p] = 0;
      for (int a = 0; a < region_words_c; a++) begin
        shadow[p][a] = word_t'({cache_id_t'(p), word_addr_t'(a)});
      end
    end
    for (int p = 0; p < num_ports_c; p++) begin
      for (int i = 0; i < directed_writes_c; i++) begin
        dir_data[p][i] = take_bits(32);
      end
    end
    // 4 tags over 4 sets keeps the caches thrashing
    for (int p = 0; p < num_ports_c; p++) begin
      for (int i = 0; i < random_per_port_c; i++) begin
        rnd_wr[p][i] = take_bits(1);
        rnd_gap[p][i] = take_bits(1);
        rnd_addr[p][i] = word_addr_t'(take_bits(2) * sets_c * block_words_c
                                      + take_bits(2) * block_words_c + take_bits(2));
        rnd_data[p][i] = rnd_wr[p][i] ? take_bits(32) : '0;
      end
    end
    repeat (2) @(posedge core_clk);
    @(negedge core_clk);
    reset_i = 1'b0;
    fork
      run_port(0);
      run_port(1);
    join
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      @(negedge core_clk);
    end
    repeat (4) @(negedge core_clk);
    for (int p = 0; p < num_ports_c; p++) begin
      assert (rsp_cnt[p] == acc_cnt[p]) else begin
        other_errs++;
        $display("port %0d answered %0d of %0d accepted requests", p, rsp_cnt[p], acc_cnt[p]);
      end
    end
    print_counts();
    if (value_errs == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns_c);
    other_errs++;
    $display("watchdog expired after %0d ns with responses still missing", watchdog_ns_c);
    print_counts();
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vcache/vcache_blocking.sv */
// vcache: direct-mapped write-back blocking cache serving one network column
`default_nettype none

module vcache_blocking #(
  parameter int sets_p = 16,
  parameter int num_caches_p = 2
) (
  input  logic                    core_clk,
  input  logic                    reset_i,

  input  logic                    req_v_i,
  input  mem_pkt_pkg::link_req_s  req_i,
  output logic                    req_ready_o,

  output logic                    rsp_v_o,
  output mem_pkt_pkg::link_rsp_s  rsp_o,

  output logic                    dma_v_o,
  output mem_pkt_pkg::dma_pkt_s   dma_pkt_o,
  input  logic                    dma_grant_i,

  input  logic                    fill_v_i,
  input  mem_geom_pkg::block_t    fill_i
);

  import mem_geom_pkg::*;
  import mem_pkt_pkg::*;

  localparam int off_w_lp = $clog2(block_words_c);
  localparam int index_w_lp = $clog2(sets_p);
  localparam int tag_w_lp = addr_width_c - off_w_lp - index_w_lp;

  if (sets_p < 2 || (sets_p & (sets_p - 1)) != 0) begin : g_bad_sets
    $error("sets_p must be a power of two of at least 2");
  end
  if (num_caches_p < 1 || num_caches_p > max_caches_c) begin : g_bad_caches
    $error("num_caches_p must be between 1 and max_caches_c");
  end

  typedef struct packed {
    logic [tag_w_lp-1:0]   tag;
    logic [index_w_lp-1:0] index;
    logic [off_w_lp-1:0]   off;
  } addr_s;

  typedef enum logic [2:0] {
    idle_s,
    wb_s,
    fill_req_s,
    fill_wait_s,
    respond_s
  } state_e;

  state_e              state_r;
  logic [tag_w_lp-1:0] tag_r [sets_p];
  block_t              data_r [sets_p];
  logic [sets_p-1:0]   valid_r;
  logic [sets_p-1:0]   dirty_r;

  link_req_s req_r;
  link_rsp_s rsp_r;
  logic      rsp_v_r;

  addr_s  in_addr;
  addr_s  cur_addr;
  logic   accept;
  logic   hit;
  block_t hit_line;

  function automatic word_t word_of(block_t blk, logic [off_w_lp-1:0] off);
    return blk[off*data_width_c +: data_width_c];
  endfunction

  function automatic block_t merge_word(block_t blk, logic [off_w_lp-1:0] off, word_t w);
    block_t res;
    res = blk;
    res[off*data_width_c +: data_width_c] = w;
    return res;
  endfunction

  assign in_addr = addr_s'(req_i.addr);
  assign cur_addr = addr_s'(req_r.addr);

  assign req_ready_o = (state_r == idle_s);
  assign accept = req_v_i && req_ready_o;
  assign hit = valid_r[in_addr.index] && (tag_r[in_addr.index] == in_addr.tag);
  assign hit_line = data_r[in_addr.index];

  assign rsp_v_o = rsp_v_r;
  assign rsp_o = rsp_r;

  // victim goes out first and the fill read for the missing line follows
  always_comb begin
    dma_v_o = (state_r == wb_s) || (state_r == fill_req_s);
    dma_pkt_o.write = (state_r == wb_s);
    if (state_r == wb_s) begin
      dma_pkt_o.addr = block_addr_t'({tag_r[cur_addr.index], cur_addr.index});
      dma_pkt_o.data = data_r[cur_addr.index];
    end else begin
      dma_pkt_o.addr = block_addr_t'({cur_addr.tag, cur_addr.index});
      dma_pkt_o.data = '0;
    end
  end

  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      state_r <= idle_s;
      valid_r <= '0;
      dirty_r <= '0;
      rsp_v_r <= 1'b0;
    end else begin
      rsp_v_r <= 1'b0;
      case (state_r)
        idle_s: begin
          if (accept) begin
            if (hit) begin
              rsp_v_r <= 1'b1;
              if (req_i.write) begin
                dirty_r[in_addr.index] <= 1'b1;
              end
            end else if (valid_r[in_addr.index] && dirty_r[in_addr.index]) begin
              state_r <= wb_s;
            end else begin
              state_r <= fill_req_s;
            end
          end
        end
        wb_s: begin
          if (dma_grant_i) begin
            state_r <= fill_req_s;
          end
        end
        fill_req_s: begin
          if (dma_grant_i) begin
            state_r <= fill_wait_s;
          end
        end
        fill_wait_s: begin
          if (fill_v_i) begin
            state_r <= respond_s;
            rsp_v_r <= 1'b1;
            valid_r[cur_addr.index] <= 1'b1;
            dirty_r[cur_addr.index] <= req_r.write;
          end
        end
        default: state_r <= idle_s;
      endcase
    end
  end

  // tag, data and response payload
  always_ff @(posedge core_clk) begin
    if (accept) begin
      req_r <= req_i;
    end
    if (accept && hit) begin
      rsp_r.write <= req_i.write;
      // writes answer with zero data
      rsp_r.data <= req_i.write ? '0 : word_of(hit_line, in_addr.off);
      if (req_i.write) begin
        data_r[in_addr.index] <= merge_word(hit_line, in_addr.off, req_i.data);
      end
    end
    if (state_r == fill_wait_s && fill_v_i) begin
      tag_r[cur_addr.index] <= cur_addr.tag;
      data_r[cur_addr.index] <= req_r.write ?
                                merge_word(fill_i, cur_addr.off, req_r.data) : fill_i;
      rsp_r.write <= req_r.write;
      rsp_r.data <= req_r.write ? '0 : word_of(fill_i, cur_addr.off);
    end
  end

  // a request held against a busy cache waits unchanged until taken
  assert property (@(posedge core_clk) disable iff (reset_i)
    req_v_i && !req_ready_o |=> req_v_i && $stable(req_i));

  // returns routed by the arbiter only while this cache waits for one
  assert property (@(posedge core_clk) disable iff (reset_i)
    fill_v_i |-> state_r == fill_wait_s);

  assert property (@(posedge core_clk) disable iff (reset_i)
    dma_v_o && !dma_grant_i |=> dma_v_o && $stable(dma_pkt_o));

endmodule

`default_nettype wire
